/* sim.f */
+incdir+include
rtl/desc_pkg.sv
rtl/desc_check.sv
rtl/desc_delay.sv
rtl/desc_fifo.sv
rtl/desc_path.sv
dv/desc_path_props.sv
dv/desc_path_tb.sv

/* Makefile */
# Verilator build and run of the descriptor path testbench

BUILD := obj_dir

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module desc_path_tb \
		-f sim.f --Mdir $(BUILD) -o desc_path_sim
	$(BUILD)/desc_path_sim > sim.log 2>&1; cat sim.log
	grep -q 'All tests passed!' sim.log

clean:
	rm -rf $(BUILD) sim.log

/* dv/desc_path_tb.sv */
`default_nettype none

`include "desc_settings.svh"

module desc_path_tb;

    localparam int WAIT_LIMIT   = 200;
    localparam int STREAM_COUNT = 200;
    localparam int STREAM_LIMIT = 20000;
    localparam int OVER_MIN     = `DESC_MAX_PKT_SIZE + 1;
    localparam int OVER_SPAN    = (1 << `DESC_SIZE_WID) - OVER_MIN;

    localparam logic [`DESC_ADDR_WID-1:0] ALIGN      = `DESC_ADDR_WID'(1) << `DESC_ALIGN_BITS;
    localparam logic [`DESC_ADDR_WID-1:0] ALIGN_MASK = ALIGN - `DESC_ADDR_WID'(1);

    logic                         clk;
    logic                         rst_n;
    logic                         in_vld;
    logic                         in_rdy;
    logic [`DESC_ADDR_WID-1:0]    in_addr;
    logic [`DESC_SIZE_WID-1:0]    in_size;
    logic [`DESC_META_WID-1:0]    in_meta;
    logic                         in_err;
    logic                         out_vld;
    logic                         out_rdy;
    logic [`DESC_ADDR_WID-1:0]    out_addr;
    logic [`DESC_SIZE_WID-1:0]    out_size;
    logic [`DESC_META_WID-1:0]    out_meta;
    logic                         out_err;
    logic [`DESC_ERR_CNT_WID-1:0] err_cnt;

    // Expected outputs in order
    desc_pkg::desc_t exp_q[$];

    int          checks;
    int          errors;
    int          timeouts;
    int          num_in;
    int          exp_err_cnt;
    logic        stream_done;
    logic [31:0] rnd_state;
    logic [31:0] rdy_state;

    desc_path desc_path_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_vld   (in_vld),
        .in_rdy   (in_rdy),
        .in_addr  (in_addr),
        .in_size  (in_size),
        .in_meta  (in_meta),
        .in_err   (in_err),
        .out_vld  (out_vld),
        .out_rdy  (out_rdy),
        .out_addr (out_addr),
        .out_size (out_size),
        .out_meta (out_meta),
        .out_err  (out_err),
        .err_cnt  (err_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Flagged for zero or oversize size, misaligned address or err already set
    function automatic logic flag_expected(input desc_pkg::desc_t d);
        return d.err || (d.size == '0) || (int'(d.size) > `DESC_MAX_PKT_SIZE)
            || ((d.addr % ALIGN) != '0);
    endfunction

    function automatic desc_pkg::desc_t make_desc(
        input logic [`DESC_ADDR_WID-1:0] addr,
        input logic [`DESC_SIZE_WID-1:0] size,
        input logic [`DESC_META_WID-1:0] meta,
        input logic                      err
    );
        desc_pkg::desc_t d;
        d.addr = addr;
        d.size = size;
        d.meta = meta;
        d.err  = err;
        return d;
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Fail at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, want);
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("Timeout at %0t: %s", $time, what);
    endtask

    task automatic next_random(output logic [31:0] r);
        rnd_state = xorshift32(rnd_state);
        r = rnd_state;
    endtask

    task automatic random_desc(output desc_pkg::desc_t d);
        logic [31:0] r_addr;
        logic [31:0] r_size;
        logic [31:0] r_misc;
        next_random(r_addr);
        next_random(r_size);
        next_random(r_misc);
        d.addr = r_addr & ~ALIGN_MASK;
        d.size = `DESC_SIZE_WID'(1 + r_size % `DESC_MAX_PKT_SIZE);
        d.meta = r_misc[`DESC_META_WID-1:0];
        d.err  = 1'b0;
        // About one in eight carries a fault
        if (r_misc[10:8] == 3'd0) begin
            case (r_misc[12:11])
                2'd0:    d.size = '0;
                2'd1:    d.size = `DESC_SIZE_WID'(OVER_MIN + r_size % OVER_SPAN);
                2'd2:    d.addr = d.addr | `DESC_ADDR_WID'(r_misc[13 +: `DESC_ALIGN_BITS])
                             | `DESC_ADDR_WID'(1);
                default: d.err = 1'b1;
            endcase
        end
    endtask

    // Offer for one cycle and sample in_rdy at the falling edge
    task automatic offer(input desc_pkg::desc_t d, output logic accepted);
        desc_pkg::desc_t want;
        in_vld  = 1'b1;
        in_addr = d.addr;
        in_size = d.size;
        in_meta = d.meta;
        in_err  = d.err;
        @(negedge clk);
        accepted = in_rdy;
        if (accepted) begin
            want = d;
            want.err = flag_expected(d);
            exp_q.push_back(want);
            num_in++;
            if (want.err) begin
                exp_err_cnt++;
            end
        end
        @(posedge clk);
        #1;
    endtask

    task automatic send(input desc_pkg::desc_t d);
        logic accepted;
        int   waited;
        accepted = 1'b0;
        waited   = 0;
        while (!accepted && waited < WAIT_LIMIT) begin
            offer(d, accepted);
            waited++;
        end
        if (!accepted) begin
            report_timeout("in_rdy never rose for a pending descriptor");
        end
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (exp_q.size() != 0) begin
            report_timeout("expected descriptors never left the path");
        end
    endtask

    // Output scoreboard
    always @(negedge clk) begin : scoreboard
        desc_pkg::desc_t want;
        if (rst_n && out_vld && out_rdy) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Unexpected descriptor at %0t, address 0x%0h", $time, out_addr);
            end else begin
                want = exp_q.pop_front();
                check("out_addr", 64'(out_addr), 64'(want.addr));
                check("out_size", 64'(out_size), 64'(want.size));
                check("out_meta", 64'(out_meta), 64'(want.meta));
                check("out_err", 64'(out_err), 64'(want.err));
            end
        end
    end

    task automatic test_latency();
        int edges;
        out_rdy = 1'b1;
        send(make_desc(32'h0000_1040, `DESC_SIZE_WID'(64), 8'h5a, 1'b0));
        in_vld = 1'b0;
        // Accept edge counts as the first
        edges = 1;
        while (!out_vld && edges < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            edges++;
        end
        if (!out_vld) begin
            report_timeout("out_vld never rose in the latency test");
        end else begin
            check("latency in edges", 64'(edges), 64'(`DESC_DELAY_STAGES + 1));
            check("out_err", 64'(out_err), 64'd0);
        end
        wait_drained();
    endtask

    task automatic test_error_flags();
        out_rdy = 1'b1;
        send(make_desc(32'h0000_2000, '0, 8'h11, 1'b0));
        send(make_desc(32'h0000_3000, `DESC_SIZE_WID'(`DESC_MAX_PKT_SIZE + 1), 8'h22, 1'b0));
        send(make_desc(32'h0000_4004, `DESC_SIZE_WID'(256), 8'h33, 1'b0));
        send(make_desc(32'h0000_5000, `DESC_SIZE_WID'(512), 8'h44, 1'b1));
        in_vld = 1'b0;
        wait_drained();
        @(posedge clk);
        #1;
        check("err_cnt", 64'(err_cnt), 64'd4);
    endtask

    task automatic test_back_pressure();
        desc_pkg::desc_t d;
        logic            accepted;
        int              n;
        int              in_before;
        out_rdy    = 1'b0;
        in_before  = num_in;
        accepted   = 1'b1;
        n          = 0;
        while (accepted && n < WAIT_LIMIT) begin
            d = make_desc(32'h0010_0000 + 32'(n * 64), `DESC_SIZE_WID'(100 + n),
                          `DESC_META_WID'(n), 1'b0);
            offer(d, accepted);
            n++;
        end
        if (accepted) begin
            report_timeout("in_rdy never fell under back-pressure");
        end
        // Full FIFO plus a full stalled pipe
        check("accepted while stalled", 64'(num_in - in_before),
              64'(`DESC_FIFO_DEPTH + `DESC_DELAY_STAGES));
        // Oldest descriptor waits at the head
        check("out_addr while stalled", 64'(out_addr), 64'(32'h0010_0000));
        check("out_vld while stalled", 64'(out_vld), 64'd1);
        out_rdy = 1'b1;
        send(d);
        in_vld = 1'b0;
        wait_drained();
    endtask

    task automatic test_random_stream();
        desc_pkg::desc_t d;
        int              cycles;
        stream_done = 1'b0;
        cycles      = 0;
        fork
            begin
                for (int i = 0; i < STREAM_COUNT; i++) begin
                    random_desc(d);
                    send(d);
                end
                in_vld      = 1'b0;
                stream_done = 1'b1;
            end
            begin
                // out_rdy high about three cycles in four
                while (!stream_done && cycles < STREAM_LIMIT) begin
                    rdy_state = xorshift32(rdy_state);
                    out_rdy   = rdy_state[0] | rdy_state[1];
                    @(posedge clk);
                    #1;
                    cycles++;
                end
            end
        join
        if (!stream_done) begin
            report_timeout("random stream did not finish");
        end
        out_rdy = 1'b1;
        wait_drained();
        @(posedge clk);
        #1;
        check("err_cnt", 64'(err_cnt), 64'(exp_err_cnt));
    endtask

    task automatic test_reset_traffic();
        out_rdy = 1'b0;
        for (int i = 0; i < 6; i++) begin
            send(make_desc(32'h0020_0000 + 32'(i * 64), `DESC_SIZE_WID'(i == 1 ? 0 : 128),
                           `DESC_META_WID'(i), 1'b0));
        end
        in_vld = 1'b0;
        rst_n  = 1'b0;
        exp_q.delete();
        exp_err_cnt = 0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check("out_vld after reset", 64'(out_vld), 64'd0);
        check("err_cnt after reset", 64'(err_cnt), 64'd0);
        check("in_rdy after reset", 64'(in_rdy), 64'd1);
        out_rdy = 1'b1;
        send(make_desc(32'h0030_0040, `DESC_SIZE_WID'(1500), 8'h77, 1'b0));
        in_vld = 1'b0;
        wait_drained();
    endtask

    initial begin
        rst_n       = 1'b0;
        in_vld      = 1'b0;
        in_addr     = '0;
        in_size     = '0;
        in_meta     = '0;
        in_err      = 1'b0;
        out_rdy     = 1'b0;
        checks      = 0;
        errors      = 0;
        timeouts    = 0;
        num_in      = 0;
        exp_err_cnt = 0;
        stream_done = 1'b0;
        rnd_state   = 32'd62;
        rdy_state   = ~32'd62;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_latency();
        test_error_flags();
        test_back_pressure();
        test_random_stream();
        test_reset_traffic();
        $display("Checks: %0d  Errors: %0d  Timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule : desc_path_tb

`default_nettype wire

/* dv/desc_path_props.sv */
`default_nettype none

`include "desc_settings.svh"

module desc_path_props (
    input logic                         clk,
    input logic                         rst_n,
    input logic                         out_vld,
    input logic                         out_rdy,
    input logic [`DESC_ADDR_WID-1:0]    out_addr,
    input logic [`DESC_SIZE_WID-1:0]    out_size,
    input logic [`DESC_META_WID-1:0]    out_meta,
    input logic                         out_err,
    input logic [`DESC_ERR_CNT_WID-1:0] err_cnt
);

    // Output side idles right after reset
    vld_low_after_reset: assert property (
        @(posedge clk) !rst_n |=> !out_vld
    ) else $error("out_vld high in the cycle after reset");

    // Stalled descriptor must hold
    hold_while_stalled: assert property (
        @(posedge clk) disable iff (!rst_n)
        (out_vld && !out_rdy) |=>
            (out_vld && $stable({out_addr, out_size, out_meta, out_err}))
    ) else $error("out_ payload changed while stalled");

    cnt_monotonic: assert property (
        @(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> (err_cnt >= $past(err_cnt))
    ) else $error("err_cnt decreased outside reset");

endmodule : desc_path_props

bind desc_path desc_path_props desc_path_props_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .out_vld  (out_vld),
    .out_rdy  (out_rdy),
    .out_addr (out_addr),
    .out_size (out_size),
    .out_meta (out_meta),
    .out_err  (out_err),
    .err_cnt  (err_cnt)
);

`default_nettype wire

/* rtl/desc_path.sv */
`default_nettype none

`include "desc_settings.svh"

module desc_path (
    input  logic                         clk,
    input  logic                         rst_n,

    input  logic                         in_vld,
    output logic                         in_rdy,
    input  logic [`DESC_ADDR_WID-1:0]    in_addr,
    input  logic [`DESC_SIZE_WID-1:0]    in_size,
    input  logic [`DESC_META_WID-1:0]    in_meta,
    input  logic                         in_err,

    output logic                         out_vld,
    input  logic                         out_rdy,
    output logic [`DESC_ADDR_WID-1:0]    out_addr,
    output logic [`DESC_SIZE_WID-1:0]    out_size,
    output logic [`DESC_META_WID-1:0]    out_meta,
    output logic                         out_err,

    output logic [`DESC_ERR_CNT_WID-1:0] err_cnt
);

    // Checker output
    logic                      chk_vld;
    logic                      chk_rdy;
    logic [`DESC_ADDR_WID-1:0] chk_addr;
    logic [`DESC_SIZE_WID-1:0] chk_size;
    logic [`DESC_META_WID-1:0] chk_meta;
    logic                      chk_err;
    desc_pkg::desc_t           chk_desc;

    // Delay pipe output into the FIFO
    logic                      dly_vld;
    logic                      dly_rdy;
    desc_pkg::desc_t           dly_desc;

    desc_pkg::desc_t           fifo_desc;

    desc_check desc_check_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_vld   (in_vld),
        .in_addr  (in_addr),
        .in_size  (in_size),
        .in_meta  (in_meta),
        .in_err   (in_err),
        .in_rdy   (in_rdy),
        .out_vld  (chk_vld),
        .out_addr (chk_addr),
        .out_size (chk_size),
        .out_meta (chk_meta),
        .out_err  (chk_err),
        .out_rdy  (chk_rdy),
        .err_cnt  (err_cnt)
    );

    assign chk_desc.addr = chk_addr;
    assign chk_desc.size = chk_size;
    assign chk_desc.meta = chk_meta;
    assign chk_desc.err  = chk_err;

    desc_delay #(
        .STAGES    (`DESC_DELAY_STAGES),
        .payload_t (desc_pkg::desc_t)
    ) desc_delay_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_vld   (chk_vld),
        .in_data  (chk_desc),
        .in_rdy   (chk_rdy),
        .out_vld  (dly_vld),
        .out_data (dly_desc),
        .out_rdy  (dly_rdy)
    );

    // FIFO write ready is its not-full flag
    desc_fifo #(
        .DEPTH     (`DESC_FIFO_DEPTH),
        .payload_t (desc_pkg::desc_t)
    ) desc_fifo_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_vld   (dly_vld),
        .in_data  (dly_desc),
        .in_rdy   (dly_rdy),
        .out_vld  (out_vld),
        .out_data (fifo_desc),
        .out_rdy  (out_rdy)
    );

    assign out_addr = fifo_desc.addr;
    assign out_size = fifo_desc.size;
    assign out_meta = fifo_desc.meta;
    assign out_err  = fifo_desc.err;

endmodule : desc_path

`default_nettype wire

/* rtl/desc_fifo.sv */
`default_nettype none

`include "desc_settings.svh"

module desc_fifo #(
    parameter int  DEPTH     = `DESC_FIFO_DEPTH,
    parameter type payload_t = desc_pkg::desc_t
) (
    input  logic     clk,
    input  logic     rst_n,

    input  logic     in_vld,
    input  payload_t in_data,
    output logic     in_rdy,

    output logic     out_vld,
    output payload_t out_data,
    input  logic     out_rdy
);

    localparam int PTR_WID = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_WID = $clog2(DEPTH + 1);

    localparam logic [PTR_WID-1:0] PTR_LAST = PTR_WID'(DEPTH - 1);
    localparam logic [CNT_WID-1:0] CNT_FULL = CNT_WID'(DEPTH);

    payload_t mem [DEPTH];

    logic [PTR_WID-1:0] wr_ptr;
    logic [PTR_WID-1:0] rd_ptr;
    logic [CNT_WID-1:0] count;

    logic full;
    logic empty;
    logic wr_en;
    logic rd_en;

    assign full  = (count == CNT_FULL);
    assign empty = (count == '0);

    assign in_rdy  = !full;
    assign out_vld = !empty;

    assign wr_en = in_vld && in_rdy;
    assign rd_en = out_vld && out_rdy;

    // Storage array
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // Pointers wrap at DEPTH
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            if (wr_ptr == PTR_LAST) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (rd_en) begin
            if (rd_ptr == PTR_LAST) begin
                rd_ptr <= '0;
            end else begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Show-ahead read port
    assign out_data = mem[rd_ptr];

endmodule : desc_fifo

`default_nettype wire

/* rtl/desc_delay.sv */
`default_nettype none

`include "desc_settings.svh"

module desc_delay #(
    parameter int  STAGES    = `DESC_DELAY_STAGES,
    parameter type payload_t = desc_pkg::desc_t
) (
    input  logic     clk,
    input  logic     rst_n,

    input  logic     in_vld,
    input  payload_t in_data,
    output logic     in_rdy,

    output logic     out_vld,
    output payload_t out_data,
    input  logic     out_rdy
);

    logic     vld_q  [STAGES];
    payload_t data_q [STAGES];

    // Whole pipe stalls together including bubbles
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < STAGES; i++) begin
                vld_q[i] <= 1'b0;
            end
        end else if (out_rdy) begin
            for (int i = 1; i < STAGES; i++) begin
                vld_q[i] <= vld_q[i-1];
            end
            vld_q[0] <= in_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (out_rdy) begin
            for (int i = 1; i < STAGES; i++) begin
                data_q[i] <= data_q[i-1];
            end
            data_q[0] <= in_data;
        end
    end

    assign out_vld  = vld_q[STAGES-1];
    assign out_data = data_q[STAGES-1];

    // Accept only when the pipe moves
    assign in_rdy = out_rdy;

endmodule : desc_delay

`default_nettype wire

/* rtl/desc_check.sv */
`default_nettype none

`include "desc_settings.svh"

module desc_check (
    input  logic                         clk,
    input  logic                         rst_n,

    input  logic                         in_vld,
    input  logic [`DESC_ADDR_WID-1:0]    in_addr,
    input  logic [`DESC_SIZE_WID-1:0]    in_size,
    input  logic [`DESC_META_WID-1:0]    in_meta,
    input  logic                         in_err,
    output logic                         in_rdy,

    output logic                         out_vld,
    output logic [`DESC_ADDR_WID-1:0]    out_addr,
    output logic [`DESC_SIZE_WID-1:0]    out_size,
    output logic [`DESC_META_WID-1:0]    out_meta,
    output logic                         out_err,
    input  logic                         out_rdy,

    output logic [`DESC_ERR_CNT_WID-1:0] err_cnt
);

    localparam logic [`DESC_SIZE_WID-1:0] MAX_SIZE = `DESC_SIZE_WID'(`DESC_MAX_PKT_SIZE);

    logic size_zero;
    logic size_over;
    logic addr_misaligned;
    logic xfer;

    // Individual fault checks
    assign size_zero       = (in_size == '0);
    assign size_over       = (in_size > MAX_SIZE);
    assign addr_misaligned = |in_addr[`DESC_ALIGN_BITS-1:0];

    // Descriptor passes straight through
    assign out_vld  = in_vld;
    assign out_addr = in_addr;
    assign out_size = in_size;
    assign out_meta = in_meta;
    assign out_err  = in_err | size_zero | size_over | addr_misaligned;

    assign in_rdy = out_rdy;

    assign xfer = out_vld && out_rdy;

    // Saturating count of flagged transfers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            err_cnt <= '0;
        end else if (xfer && out_err && (err_cnt != '1)) begin
            err_cnt <= err_cnt + 1'b1;
        end
    end

endmodule : desc_check

`default_nettype wire

/* rtl/desc_pkg.sv */
`default_nettype none

`include "desc_settings.svh"

package desc_pkg;

    // Descriptor as stored in the delay pipe and the FIFO
    typedef struct packed {
        logic [`DESC_ADDR_WID-1:0] addr;
        logic [`DESC_SIZE_WID-1:0] size;
        logic [`DESC_META_WID-1:0] meta;
        logic                      err;
    } desc_t;

endpackage : desc_pkg

`default_nettype wire

/* include/desc_settings.svh */
`ifndef DESC_SETTINGS_SVH
`define DESC_SETTINGS_SVH

// Descriptor field widths
`define DESC_ADDR_WID 32
`define DESC_META_WID 8
`define DESC_SIZE_WID 14

// Largest legal packet in bytes
`define DESC_MAX_PKT_SIZE 9216

// Low address bits that must be zero for 64-byte buffers
`define DESC_ALIGN_BITS 6

// Path geometry
`define DESC_DELAY_STAGES 3
`define DESC_FIFO_DEPTH 8

// Flagged descriptor counter
`define DESC_ERR_CNT_WID 16

`endif
